/* Bender.yml */
package:
  name: ac97_audio

sources:
  - src/ac97_pkg.sv
  - src/switch_debouncer.sv
  - src/volume_control.sv
  - src/ac97_command_sequencer.sv
  - src/command_buffer.sv
  - src/ac97_frame_engine.sv
  - src/ac97_audio_top.sv
  - target: test
    files:
      - test/ac97_audio_tb.sv

/* ac97_audio_top.f */
src/ac97_pkg.sv
src/switch_debouncer.sv
src/volume_control.sv
src/ac97_command_sequencer.sv
src/command_buffer.sv
src/ac97_frame_engine.sv
src/ac97_audio_top.sv
test/ac97_audio_tb.sv

/* src/ac97_audio_top.sv */
`timescale 1ns/10ps

module ac97_audio_top (
  input logic clock,
  input logic reset,
  input logic button_up,
  input logic button_down,
  input ac97_pkg::sample_t audio_out_data,
  output ac97_pkg::sample_t audio_in_data,
  output logic sample_strobe,
  output logic audio_reset_b,
  output logic ac97_synch,
  output logic ac97_sdata_out,
  input logic ac97_sdata_in
);
  import ac97_pkg::*;

  volume_t volume;
  // sequencer to buffer handshake
  logic cmd_req;
  logic cmd_ack;
  cmd_word_t cmd_word;
  // buffer to frame engine
  logic cmd_valid;
  logic cmd_take;
  cmd_word_t cmd_held;

  volume_control volume_control_inst (
    .clock(clock),
    .reset(reset),
    .button_up(button_up),
    .button_down(button_down),
    .volume(volume)
  );

  ac97_command_sequencer ac97_command_sequencer_inst (
    .clock(clock),
    .reset(reset),
    .volume(volume),
    .cmd_req(cmd_req),
    .cmd_ack(cmd_ack),
    .cmd_word(cmd_word)
  );

  command_buffer command_buffer_inst (
    .clock(clock),
    .reset(reset),
    .cmd_req(cmd_req),
    .cmd_word(cmd_word),
    .cmd_ack(cmd_ack),
    .cmd_take(cmd_take),
    .cmd_valid(cmd_valid),
    .cmd_held(cmd_held)
  );

  ac97_frame_engine ac97_frame_engine_inst (
    .clock(clock),
    .reset(reset),
    .cmd_valid(cmd_valid),
    .cmd_held(cmd_held),
    .cmd_take(cmd_take),
    .audio_out_data(audio_out_data),
    .audio_in_data(audio_in_data),
    .sample_strobe(sample_strobe),
    .audio_reset_b(audio_reset_b),
    .ac97_synch(ac97_synch),
    .ac97_sdata_out(ac97_sdata_out),
    .ac97_sdata_in(ac97_sdata_in)
  );

endmodule

/* src/ac97_command_sequencer.sv */
`timescale 1ns/10ps

module ac97_command_sequencer (
  input logic clock,
  input logic reset,
  input ac97_pkg::volume_t volume,
  output logic cmd_req,
  input logic cmd_ack,
  output ac97_pkg::cmd_word_t cmd_word
);
  import ac97_pkg::*;

  logic [$clog2(CMD_COUNT)-1:0] cmd_index;
  cmd_word_t next_cmd;
  // codec wants attenuation, not volume
  volume_t attenuation;

  assign attenuation = VOLUME_MAX - volume;

  //////////////////////////////////////////////////
  // command table
  //////////////////////////////////////////////////

  always_comb begin
    next_cmd = '0;
    case (cmd_index)
      1: begin
        next_cmd.stereo.addr = REG_HEADPHONE_VOL;
        next_cmd.stereo.left = attenuation;
        next_cmd.stereo.right = attenuation;
      end
      2: next_cmd.raw = '{REG_PCM_VOL, 16'h0808};
      3: begin
        // same source on both channels
        next_cmd.stereo.addr = REG_RECORD_SELECT;
        next_cmd.stereo.left = volume_t'(RECORD_SOURCE_MIC);
        next_cmd.stereo.right = volume_t'(RECORD_SOURCE_MIC);
      end
      // record gain at max
      4: next_cmd.raw = '{REG_RECORD_GAIN, 16'h0F0F};
      // +20 dB mic boost
      5: next_cmd.raw = '{REG_MIC_GAIN, 16'h8048};
      6: next_cmd.raw = '{REG_BEEP_VOL, 16'h0000};
      // pcm out bypasses 3d mix
      7: next_cmd.raw = '{REG_GENERAL, 16'h8000};
      default: next_cmd.raw = '{REG_READ_ID, 16'h0000};
    endcase
  end

  //////////////////////////////////////////////////
  // four-phase master side
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      cmd_req <= 1'b0;
      cmd_index <= '0;
    end else if (cmd_req && cmd_ack) begin
      // word taken, release and step on
      cmd_req <= 1'b0;
      cmd_index <= (cmd_index == CMD_COUNT - 1) ? '0 : cmd_index + 1'b1;
    end else if (!cmd_req && !cmd_ack) begin
      cmd_req <= 1'b1;
    end
  end

  // word settles in the same edge req rises
  always_ff @(posedge clock) begin
    if (!cmd_req && !cmd_ack) begin
      cmd_word <= next_cmd;
    end
  end

endmodule

/* src/ac97_frame_engine.sv */
`timescale 1ns/10ps

module ac97_frame_engine (
  input logic clock,
  input logic reset,
  input logic cmd_valid,
  input ac97_pkg::cmd_word_t cmd_held,
  output logic cmd_take,
  input ac97_pkg::sample_t audio_out_data,
  output ac97_pkg::sample_t audio_in_data,
  output logic sample_strobe,
  output logic audio_reset_b,
  output logic ac97_synch,
  output logic ac97_sdata_out,
  input logic ac97_sdata_in
);
  import ac97_pkg::*;

  logic [$clog2(CODEC_RESET_CYCLES)-1:0] reset_count;
  logic [$clog2(FRAME_BITS)-1:0] bit_count;
  // last cycle of the codec reset delay
  logic codec_release;

  // per-frame latches
  logic l_cmd_valid;
  cmd_word_t l_cmd;
  sample_t l_sample;
  // sample taken at the strobe
  sample_t sample_reg;

  logic [SLOT_BITS-1:0] addr_slot;
  logic [SLOT_BITS-1:0] data_slot;
  logic [SLOT_BITS-1:0] pcm_slot;
  logic [SLOT_BITS-1:0] left_shift;
  logic next_bit;

  // msb-first bit of a slot at a given offset
  function automatic logic slot_bit(input logic [SLOT_BITS-1:0] slot, input int offset);
    return slot[SLOT_BITS-1-offset];
  endfunction

  //////////////////////////////////////////////////
  // codec reset and bit counter
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      reset_count <= '0;
      audio_reset_b <= 1'b0;
    end else if (!audio_reset_b) begin
      if (reset_count == CODEC_RESET_CYCLES - 1) begin
        audio_reset_b <= 1'b1;
      end else begin
        reset_count <= reset_count + 1'b1;
      end
    end
  end

  assign codec_release = !audio_reset_b && reset_count == CODEC_RESET_CYCLES - 1;

  // held at 0 until the codec is out of reset
  always_ff @(posedge clock) begin
    if (reset) begin
      bit_count <= '0;
    end else if (audio_reset_b) begin
      bit_count <= (bit_count == FRAME_BITS - 1) ? '0 : bit_count + 1'b1;
    end
  end

  assign sample_strobe = (bit_count == STROBE_COUNT);
  assign cmd_take = (bit_count == LATCH_COUNT);

  // sync leads the first tag bit by one count, first frame included
  always_ff @(posedge clock) begin
    if (reset) begin
      ac97_synch <= 1'b0;
    end else if (bit_count == LATCH_COUNT || codec_release) begin
      ac97_synch <= 1'b1;
    end else if (bit_count == SYNC_BITS - 1) begin
      ac97_synch <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // frame latches
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (sample_strobe) begin
      sample_reg <= audio_out_data;
    end
  end

  // first frame goes out empty
  always_ff @(posedge clock) begin
    if (reset) begin
      l_cmd_valid <= 1'b0;
      l_sample <= '0;
    end else if (cmd_take) begin
      l_cmd_valid <= cmd_valid;
      l_sample <= sample_reg;
    end
  end

  always_ff @(posedge clock) begin
    if (cmd_take) begin
      l_cmd <= cmd_held;
    end
  end

  //////////////////////////////////////////////////
  // slot serializer
  //////////////////////////////////////////////////

  // left justified, zero padded
  assign addr_slot = {l_cmd.raw.addr, 12'h000};
  assign data_slot = {l_cmd.raw.data, 4'h0};
  assign pcm_slot = {l_sample, 12'h000};

  always_comb begin
    if (bit_count < SYNC_BITS) begin
      // slot 0 tags
      case (bit_count[3:0])
        4'd0: next_bit = 1'b1;
        4'd1, 4'd2: next_bit = l_cmd_valid;
        // left and right always valid
        4'd3, 4'd4: next_bit = 1'b1;
        default: next_bit = 1'b0;
      endcase
    end else if (bit_count < CMD_DATA_START) begin
      next_bit = l_cmd_valid & slot_bit(addr_slot, bit_count - CMD_ADDR_START);
    end else if (bit_count < LEFT_START) begin
      next_bit = l_cmd_valid & slot_bit(data_slot, bit_count - CMD_DATA_START);
    end else if (bit_count < RIGHT_START) begin
      next_bit = slot_bit(pcm_slot, bit_count - LEFT_START);
    end else if (bit_count < RIGHT_START + SLOT_BITS) begin
      // mono, right copies left
      next_bit = slot_bit(pcm_slot, bit_count - RIGHT_START);
    end else begin
      next_bit = 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ac97_sdata_out <= 1'b0;
    end else begin
      ac97_sdata_out <= audio_reset_b & next_bit;
    end
  end

  //////////////////////////////////////////////////
  // left slot capture
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (bit_count >= LEFT_CAPTURE_START && bit_count < LEFT_CAPTURE_START + SLOT_BITS) begin
      left_shift <= {left_shift[SLOT_BITS-2:0], ac97_sdata_in};
    end
  end

  // top 8 bits once the 20th bit is in
  always_ff @(posedge clock) begin
    if (reset) begin
      audio_in_data <= '0;
    end else if (bit_count == LEFT_CAPTURE_START + SLOT_BITS - 1) begin
      audio_in_data <= left_shift[SLOT_BITS-2 -: SAMPLE_BITS];
    end
  end

endmodule

/* src/ac97_pkg.sv */
package ac97_pkg;

  //////////////////////////////////////////////////
  // frame layout, one serial bit per clock
  //////////////////////////////////////////////////

  localparam int FRAME_BITS = 256;
  // slot 0 length, sync high for all of it
  localparam int SYNC_BITS = 16;
  localparam int STROBE_COUNT = 128;
  // last count of a frame, next frame data latched here
  localparam int LATCH_COUNT = 255;
  localparam int SLOT_BITS = 20;

  // first bit count of slots 1 to 4
  localparam int CMD_ADDR_START = 16;
  localparam int CMD_DATA_START = 36;
  localparam int LEFT_START = 56;
  localparam int RIGHT_START = 76;
  // input bits arrive one count after the matching output bit
  localparam int LEFT_CAPTURE_START = 57;

  // user sample and volume widths
  localparam int SAMPLE_BITS = 8;
  localparam int VOLUME_BITS = 5;

  typedef logic [VOLUME_BITS-1:0] volume_t;
  typedef logic [SAMPLE_BITS-1:0] sample_t;

  localparam volume_t VOLUME_MAX = volume_t'(31);
  localparam volume_t VOLUME_RESET = volume_t'(8);

  // short delays for simulation
  localparam int DEBOUNCE_CYCLES = 20;
  localparam int CODEC_RESET_CYCLES = 64;

  //////////////////////////////////////////////////
  // codec registers
  //////////////////////////////////////////////////

  localparam logic [7:0] REG_READ_ID = 8'h80;
  localparam logic [7:0] REG_HEADPHONE_VOL = 8'h04;
  localparam logic [7:0] REG_PCM_VOL = 8'h18;
  localparam logic [7:0] REG_RECORD_SELECT = 8'h1A;
  localparam logic [7:0] REG_RECORD_GAIN = 8'h1C;
  localparam logic [7:0] REG_MIC_GAIN = 8'h0E;
  localparam logic [7:0] REG_BEEP_VOL = 8'h0A;
  localparam logic [7:0] REG_GENERAL = 8'h20;

  // record source code, mic
  localparam logic [2:0] RECORD_SOURCE_MIC = 3'd0;
  localparam int CMD_COUNT = 8;

  // address plus 16-bit data
  typedef struct packed {
    logic [7:0] addr;
    logic [15:0] data;
  } cmd_raw_t;

  // address plus left and right level fields
  typedef struct packed {
    logic [7:0] addr;
    logic [2:0] pad_left;
    volume_t left;
    logic [2:0] pad_right;
    volume_t right;
  } cmd_stereo_t;

  typedef union packed {
    cmd_raw_t raw;
    cmd_stereo_t stereo;
  } cmd_word_t;

endpackage

/* src/command_buffer.sv */
`timescale 1ns/10ps

module command_buffer (
  input logic clock,
  input logic reset,
  input logic cmd_req,
  input ac97_pkg::cmd_word_t cmd_word,
  output logic cmd_ack,
  input logic cmd_take,
  output logic cmd_valid,
  output ac97_pkg::cmd_word_t cmd_held
);

  // new request, and room for it
  logic capture;

  assign capture = cmd_req && !cmd_ack && !cmd_valid;

  always_ff @(posedge clock) begin
    if (reset) begin
      cmd_ack <= 1'b0;
      cmd_valid <= 1'b0;
    end else begin
      // frame engine empties the entry once per frame
      if (cmd_take) begin
        cmd_valid <= 1'b0;
      end
      if (capture) begin
        cmd_valid <= 1'b1;
        cmd_ack <= 1'b1;
      end else if (cmd_ack && !cmd_req) begin
        cmd_ack <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (capture) begin
      cmd_held <= cmd_word;
    end
  end

endmodule

/* src/switch_debouncer.sv */
`timescale 1ns/10ps

module switch_debouncer (
  input logic clock,
  input logic reset,
  input logic noisy,
  output logic clean
);
  import ac97_pkg::*;

  // last seen input level
  logic last;
  // stable time so far
  logic [$clog2(DEBOUNCE_CYCLES+1)-1:0] count;

  always_ff @(posedge clock) begin
    if (reset) begin
      last <= noisy;
      clean <= noisy;
      count <= '0;
    end else if (noisy != last) begin
      // input moved, start timing again
      last <= noisy;
      count <= '0;
    end else if (count == DEBOUNCE_CYCLES) begin
      clean <= last;
    end else begin
      count <= count + 1'b1;
    end
  end

endmodule

/* src/volume_control.sv */
`timescale 1ns/10ps

module volume_control (
  input logic clock,
  input logic reset,
  input logic button_up,
  input logic button_down,
  output ac97_pkg::volume_t volume
);
  import ac97_pkg::*;

  logic up_clean;
  logic down_clean;
  logic up_prev;
  logic down_prev;
  logic up_edge;
  logic down_edge;

  switch_debouncer up_debouncer (
    .clock(clock),
    .reset(reset),
    .noisy(button_up),
    .clean(up_clean)
  );

  switch_debouncer down_debouncer (
    .clock(clock),
    .reset(reset),
    .noisy(button_down),
    .clean(down_clean)
  );

  // one pulse per press
  assign up_edge = up_clean & ~up_prev;
  assign down_edge = down_clean & ~down_prev;

  always_ff @(posedge clock) begin
    if (reset) begin
      // a button held through reset gives no step
      up_prev <= 1'b1;
      down_prev <= 1'b1;
      volume <= VOLUME_RESET;
    end else begin
      up_prev <= up_clean;
      down_prev <= down_clean;
      // saturate at both ends, both pressed cancels
      if (up_edge && !down_edge && volume != VOLUME_MAX) begin
        volume <= volume + 1'b1;
      end else if (down_edge && !up_edge && volume != '0) begin
        volume <= volume - 1'b1;
      end
    end
  end

endmodule

/* test/ac97_audio_tb.sv */
`timescale 1ns/10ps

module ac97_audio_tb;
  import ac97_pkg::*;

  // counter slots watched by the tests
  localparam int FRAMES = 0;
  localparam int COMMANDS = 1;
  localparam int HEADPHONES = 2;
  localparam int PCM_FRAMES = 3;
  // slots 0 to 4 of each frame
  localparam int DECODED_BITS = RIGHT_START + SLOT_BITS;

  logic clock;
  logic reset;
  logic button_up;
  logic button_down;
  sample_t audio_out_data = '0;
  sample_t audio_in_data;
  logic sample_strobe;
  logic audio_reset_b;
  logic ac97_synch;
  logic ac97_sdata_out;
  logic ac97_sdata_in = 1'b0;

  integer seed = 52;
  integer rand_word;
  int errors = 0;
  int tests_run = 0;
  int test_errors_start = 0;
  logic timed_out = 1'b0;
  int event_count [4] = '{0, 0, 0, 0};

  // serial decoder state
  logic synced = 1'b0;
  logic synch_prev = 1'b0;
  int pos = 0;
  logic [DECODED_BITS-1:0] frame_word = '0;
  int exp_index = 0;
  volume_t first_headphone_level = '0;
  volume_t last_headphone_level = '0;
  // sample taken at the last strobe, and the one due in this frame
  sample_t pending_sample = '0;
  logic pending_known = 1'b0;
  sample_t frame_sample = '0;
  logic frame_sample_known = 1'b0;

  ac97_audio_top ac97_audio_top_inst (
    .clock(clock),
    .reset(reset),
    .button_up(button_up),
    .button_down(button_down),
    .audio_out_data(audio_out_data),
    .audio_in_data(audio_in_data),
    .sample_strobe(sample_strobe),
    .audio_reset_b(audio_reset_b),
    .ac97_synch(ac97_synch),
    .ac97_sdata_out(ac97_sdata_out),
    .ac97_sdata_in(ac97_sdata_in)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #50 clock = ~clock;
    end
  end

  // codec stand-in, output looped back one half cycle late
  always @(negedge clock) begin
    ac97_sdata_in <= ac97_sdata_out;
  end

  task automatic report_fail(input string msg);
    $display("FAIL %0t ns: %s", $time, msg);
    errors++;
  endtask

  // expected command table
  function automatic logic [7:0] command_address(input int index);
    case (index)
      1: return REG_HEADPHONE_VOL;
      2: return REG_PCM_VOL;
      3: return REG_RECORD_SELECT;
      4: return REG_RECORD_GAIN;
      5: return REG_MIC_GAIN;
      6: return REG_BEEP_VOL;
      7: return REG_GENERAL;
      default: return REG_READ_ID;
    endcase
  endfunction

  function automatic logic [15:0] command_data(input int index);
    case (index)
      2: return 16'h0808;
      3: return {3'b000, volume_t'(RECORD_SOURCE_MIC), 3'b000, volume_t'(RECORD_SOURCE_MIC)};
      4: return 16'h0F0F;
      5: return 16'h8048;
      7: return 16'h8000;
      default: return 16'h0000;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // frame decoder and checks
  //////////////////////////////////////////////////

  task automatic check_frame();
    logic [15:0] tags;
    logic [SLOT_BITS-1:0] addr_slot;
    logic [SLOT_BITS-1:0] data_slot;
    logic [SLOT_BITS-1:0] left_slot;
    logic [SLOT_BITS-1:0] right_slot;
    logic [15:0] data;
    tags = frame_word[95:80];
    addr_slot = frame_word[79:60];
    data_slot = frame_word[59:40];
    left_slot = frame_word[39:20];
    right_slot = frame_word[19:0];
    data = data_slot[19:4];
    assert (tags[15] && tags[12:11] == 2'b11 && tags[10:0] == '0)
      else report_fail($sformatf("slot 0 tags %h", tags));
    assert (tags[14] == tags[13])
      else report_fail("command address and data tags differ");
    assert (addr_slot[11:0] == '0 && data_slot[3:0] == '0)
      else report_fail("command slot padding not zero");
    if (tags[14]) begin
      assert (addr_slot[19:12] == command_address(exp_index))
        else report_fail($sformatf("address %h, expected %h", addr_slot[19:12],
                                   command_address(exp_index)));
      if (exp_index == 1) begin
        // stereo fields, pads zero, both levels equal
        assert (data[15:13] == '0 && data[7:5] == '0 && data[12:8] == data[4:0])
          else report_fail($sformatf("headphone data %h", data));
        last_headphone_level = data[4:0];
        event_count[HEADPHONES]++;
        if (event_count[HEADPHONES] == 1) begin
          first_headphone_level = data[4:0];
        end
      end else begin
        assert (data == command_data(exp_index))
          else report_fail($sformatf("data %h, expected %h", data, command_data(exp_index)));
      end
      exp_index = (exp_index + 1) % CMD_COUNT;
      event_count[COMMANDS]++;
    end else begin
      // empty frames only before the first command
      assert (addr_slot == '0 && data_slot == '0)
        else report_fail("empty command slots not zero");
    end
    if (frame_sample_known) begin
      assert (left_slot == {frame_sample, 12'h000} && right_slot == {frame_sample, 12'h000})
        else report_fail($sformatf("pcm slots %h %h, expected sample %h", left_slot,
                                   right_slot, frame_sample));
      assert (audio_in_data == frame_sample)
        else report_fail($sformatf("audio_in_data %h, expected %h", audio_in_data,
                                   frame_sample));
      event_count[PCM_FRAMES]++;
    end
  endtask

  // outputs settle after the rising edge, sampled here on the falling one
  always @(negedge clock) begin
    if (reset || audio_reset_b !== 1'b1) begin
      synced = 1'b0;
    end else begin
      if (ac97_synch && !synch_prev) begin
        if (synced) begin
          assert (pos == FRAME_BITS - 1)
            else report_fail($sformatf("frame lasted %0d cycles", pos + 1));
        end
        synced = 1'b1;
        pos = 0;
        event_count[FRAMES]++;
        frame_sample = pending_sample;
        frame_sample_known = pending_known;
      end else if (synced) begin
        pos++;
      end
      if (synced) begin
        assert (pos < FRAME_BITS) else report_fail("sync missing at the end of a frame");
        assert (ac97_synch == (pos < SYNC_BITS))
          else report_fail($sformatf("ac97_synch %b at frame position %0d", ac97_synch, pos));
        assert (sample_strobe == (pos == STROBE_COUNT))
          else report_fail($sformatf("sample_strobe %b at position %0d", sample_strobe, pos));
        // bit k of the frame shows up at position k+1
        if (pos >= 1 && pos <= DECODED_BITS) begin
          frame_word = {frame_word[DECODED_BITS-2:0], ac97_sdata_out};
        end
        if (pos == DECODED_BITS) begin
          check_frame();
        end
      end
    end
    synch_prev = ac97_synch;
    // new random sample for the strobe edge
    if (sample_strobe === 1'b1) begin
      rand_word = $random(seed);
      audio_out_data <= rand_word[SAMPLE_BITS-1:0];
      pending_sample = rand_word[SAMPLE_BITS-1:0];
      pending_known = 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // test helpers
  //////////////////////////////////////////////////

  task automatic wait_for_count(input int which, input int target, input int limit,
                                input string what);
    int cycles;
    cycles = 0;
    while (!timed_out && event_count[which] < target && cycles < limit) begin
      @(negedge clock);
      cycles++;
    end
    if (!timed_out && event_count[which] < target) begin
      $display("timeout after %0d cycles while waiting for %s", limit, what);
      timed_out = 1'b1;
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_errors_start) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d failed checks", name, errors - test_errors_start);
    end
  endtask

  task automatic press_button(input logic up, input int high_cycles);
    if (up) begin
      button_up = 1'b1;
    end else begin
      button_down = 1'b1;
    end
    repeat (high_cycles) @(negedge clock);
    button_up = 1'b0;
    button_down = 1'b0;
    repeat (DEBOUNCE_CYCLES + 8) @(negedge clock);
  endtask

  // the next headphone word may predate the press, so skip one
  task automatic check_level_later(input volume_t expected, input string what);
    int seen;
    seen = event_count[HEADPHONES];
    wait_for_count(HEADPHONES, seen + 2, 18 * FRAME_BITS, "headphone commands");
    assert (last_headphone_level == expected)
      else report_fail($sformatf("headphone level %0d %s, expected %0d",
                                 last_headphone_level, what, expected));
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  task automatic release_reset();
    int cycles;
    test_errors_start = errors;
    repeat (8) begin
      @(negedge clock);
      assert (audio_reset_b === 1'b0 && ac97_synch === 1'b0 && ac97_sdata_out === 1'b0
              && sample_strobe === 1'b0)
        else report_fail("codec outputs not low during reset");
      assert (ac97_audio_top_inst.cmd_req === 1'b0 && ac97_audio_top_inst.cmd_ack === 1'b0
              && ac97_audio_top_inst.cmd_valid === 1'b0)
        else report_fail("command handshake not idle during reset");
    end
    reset = 1'b0;
    cycles = 0;
    while (audio_reset_b !== 1'b1 && cycles < CODEC_RESET_CYCLES + 16) begin
      @(negedge clock);
      cycles++;
    end
    if (audio_reset_b !== 1'b1) begin
      $display("timeout, audio_reset_b never rose after reset");
      timed_out = 1'b1;
      errors++;
    end else begin
      assert (cycles == CODEC_RESET_CYCLES)
        else report_fail($sformatf("codec reset released after %0d cycles", cycles));
    end
    end_test("reset and codec release");
  endtask

  task automatic watch_frames();
    test_errors_start = errors;
    wait_for_count(FRAMES, 4, 5 * FRAME_BITS, "four sync pulses");
    end_test("frame timing");
  endtask

  task automatic follow_command_stream();
    test_errors_start = errors;
    wait_for_count(COMMANDS, 2 * CMD_COUNT + 1, (2 * CMD_COUNT + 4) * FRAME_BITS,
                   "two command sequences");
    end_test("command stream");
  endtask

  task automatic exercise_volume_buttons();
    test_errors_start = errors;
    wait_for_count(HEADPHONES, 1, 10 * FRAME_BITS, "first headphone command");
    // reset volume 8 gives attenuation 23
    assert (first_headphone_level == volume_t'(23))
      else report_fail($sformatf("first headphone level %0d", first_headphone_level));
    press_button(1'b1, DEBOUNCE_CYCLES + 8);
    check_level_later(volume_t'(22), "after one long press");
    // glitches below the debounce time
    repeat (3) press_button(1'b1, DEBOUNCE_CYCLES / 2);
    check_level_later(volume_t'(22), "after short pulses");
    repeat (VOLUME_MAX + 2) press_button(1'b1, DEBOUNCE_CYCLES + 8);
    check_level_later(volume_t'(0), "after pressing up past the top");
    repeat (VOLUME_MAX + 2) press_button(1'b0, DEBOUNCE_CYCLES + 8);
    check_level_later(volume_t'(31), "after pressing down past the bottom");
    end_test("volume buttons");
  endtask

  task automatic stream_pcm_samples();
    int seen;
    test_errors_start = errors;
    seen = event_count[PCM_FRAMES];
    wait_for_count(PCM_FRAMES, seen + 4, 6 * FRAME_BITS, "four checked pcm frames");
    end_test("pcm path");
  endtask

  initial begin
    reset = 1'b1;
    button_up = 1'b0;
    button_down = 1'b0;
    release_reset();
    watch_frames();
    follow_command_stream();
    exercise_volume_buttons();
    stream_pcm_samples();
    $display("tests run: %0d, failed checks: %0d", tests_run, errors);
    if (errors == 0 && !timed_out) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
